//--- verilog/pcie_tlp_settings.svh
// Queue depth and TLP field width macros for the PCIe TLP port
`ifndef PCIE_TLP_SETTINGS_SVH
`define PCIE_TLP_SETTINGS_SVH

// Entries held by each AFU channel queue before new TLPs are dropped
`define PCIE_TLP_QUEUE_DEPTH 4

// Width of the TLP tag, which is also carried back on a write commit
`define PCIE_TLP_TAG_W 8

// Width of the TLP address field
`define PCIE_TLP_ADDR_W 32

`endif

//--- verilog/pcie_tlp_pkg.sv
// TLP kind enum plus header, merged TX and write commit struct types
`include "pcie_tlp_settings.svh"

package pcie_tlp_pkg;

    // Payload word carried with every single-beat TLP
    localparam int TLP_DATA_W = 32;

    // Kind of request or completion carried by a TLP
    typedef enum logic [1:0]
    {
        MEM_WR = 2'd0,
        MEM_RD = 2'd1,
        CPL    = 2'd2
    } tlp_kind_e;

    // One TLP as delivered by an AFU transmit channel
    typedef struct packed
    {
        tlp_kind_e                     kind;
        logic [`PCIE_TLP_TAG_W-1:0]    tag;
        logic [`PCIE_TLP_ADDR_W-1:0]   addr;
        logic [TLP_DATA_W-1:0]         data;
    } tlp_hdr_t;

    // One TLP on the merged TX stream
    // The port bit tells which AFU channel it came from, 0 for A and 1 for B
    typedef struct packed
    {
        tlp_hdr_t hdr;
        logic     port;
    } tlp_tx_t;

    // Local write commit returned on the RX B path
    typedef struct packed
    {
        logic [`PCIE_TLP_TAG_W-1:0] tag;
        logic                       port;
    } tlp_commit_t;

endpackage

//--- verilog/tlp_port_queue.sv
// Channel FIFO with a type-parameter payload, drop on full and sticky overflow
`timescale 1ns/1ps
`include "pcie_tlp_settings.svh"

module tlp_port_queue
#(
    parameter type payload_t = logic
)
(
    input  logic     afu_csr_axi_lite_if,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     not_empty,
    output payload_t head,
    output logic     overflow
);

    localparam int DEPTH = `PCIE_TLP_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_pop;
    logic             do_push;

    // Advance a pointer around the ring, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

    // A pop frees its slot first, so a push into a full queue that is
    // draining in the same cycle still finds room
    assign do_pop  = pop && not_empty;
    assign do_push = push && (!full || do_pop);

    // The oldest entry is presented straight from the read pointer
    assign head = mem[rd_ptr];

    always_ff @(posedge afu_csr_axi_lite_if or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // There is no back-pressure, so a rejected strobe is lost for good
            if (push && !do_push)
            begin
                overflow <= 1'b1;
            end
        end
    end

    // Storage array holds payload only
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- verilog/tlp_ab_arbiter.sv
// Round-robin A/B arbiter that pops the channel queues into one TX stream
`timescale 1ns/1ps

module tlp_ab_arbiter import pcie_tlp_pkg::*;
(
    input  logic     afu_csr_axi_lite_if,
    input  logic     rst_n,
    input  logic     a_ready,
    input  tlp_hdr_t a_head,
    input  logic     b_ready,
    input  tlp_hdr_t b_head,
    output logic     a_pop,
    output logic     b_pop,
    output logic     out_valid,
    output tlp_tx_t  out
);

    // Set when B holds priority, cleared when A does
    logic turn_b;
    logic grant_a;
    logic grant_b;

    // A lone requester always wins
    // With both waiting, the port whose turn it is goes first
    always_comb
    begin
        grant_a = a_ready && (!b_ready || !turn_b);
        grant_b = b_ready && (!a_ready || turn_b);
    end

    // The pop goes back to the queue in the same cycle as the grant
    assign a_pop = grant_a;
    assign b_pop = grant_b;

    always_ff @(posedge afu_csr_axi_lite_if or negedge rst_n)
    begin
        if (!rst_n)
        begin
            turn_b    <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= grant_a || grant_b;
            // Priority passes to the other port after every grant, so
            // back-to-back contention alternates A, B, A, B
            if (grant_a)
            begin
                turn_b <= 1'b1;
            end
            else if (grant_b)
            begin
                turn_b <= 1'b0;
            end
        end
    end

    // Winning head is tagged with its source port
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (grant_b)
        begin
            out.hdr  <= b_head;
            out.port <= 1'b1;
        end
        else if (grant_a)
        begin
            out.hdr  <= a_head;
            out.port <= 1'b0;
        end
    end

endmodule

//--- verilog/tlp_local_commit.sv
// Local commit stage that registers the FIM TX stream and builds write commits
`timescale 1ns/1ps

module tlp_local_commit import pcie_tlp_pkg::*;
(
    input  logic        afu_csr_axi_lite_if,
    input  logic        rst_n,
    input  logic        in_valid,
    input  tlp_tx_t     in,
    output logic        tx_valid,
    output tlp_tx_t     tx,
    output logic        commit_valid,
    output tlp_commit_t commit
);

    logic is_wr;

    // Only memory writes get a commit, reads wait for a real completion
    assign is_wr = in_valid && (in.hdr.kind == MEM_WR);

    always_ff @(posedge afu_csr_axi_lite_if or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tx_valid     <= 1'b0;
            commit_valid <= 1'b0;
        end
        else
        begin
            tx_valid     <= in_valid;
            // Commit leaves together with the write it acknowledges
            commit_valid <= is_wr;
        end
    end

    // The TLP moves on unchanged one cycle later
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (in_valid)
        begin
            tx <= in;
        end
    end

    // Tag and port let the AFU match the commit to its own write
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (is_wr)
        begin
            commit.tag  <= in.hdr.tag;
            commit.port <= in.port;
        end
    end

endmodule

//--- verilog/pcie_ss_tlp_port.sv
// Top level of the TLP port with two channel queues, the arbiter and commit stage
`timescale 1ns/1ps

module pcie_ss_tlp_port import pcie_tlp_pkg::*;
(
    input  logic        afu_csr_axi_lite_if,
    input  logic        rst_n,
    input  logic        tx_a_valid,
    input  tlp_hdr_t    tx_a,
    input  logic        tx_b_valid,
    input  tlp_hdr_t    tx_b,
    output logic        fim_tx_valid,
    output tlp_tx_t     fim_tx,
    output logic        commit_valid,
    output tlp_commit_t commit,
    output logic [1:0]  tx_overflow
);

    // Queue heads offered to the arbiter
    logic     a_not_empty;
    tlp_hdr_t a_head;
    logic     a_pop;
    logic     b_not_empty;
    tlp_hdr_t b_head;
    logic     b_pop;

    // Merged stream between the arbiter and the commit stage
    logic    tx_arb_valid;
    tlp_tx_t tx_arb;

    // Channel A queue, overflow reported on bit 0
    tlp_port_queue
    #(
        .payload_t(tlp_hdr_t)
    )
    queue_a_i
    (
        .afu_csr_axi_lite_if(afu_csr_axi_lite_if),
        .rst_n(rst_n),
        .push(tx_a_valid),
        .push_data(tx_a),
        .pop(a_pop),
        .not_empty(a_not_empty),
        .head(a_head),
        .overflow(tx_overflow[0])
    );

    // Channel B queue, overflow reported on bit 1
    tlp_port_queue
    #(
        .payload_t(tlp_hdr_t)
    )
    queue_b_i
    (
        .afu_csr_axi_lite_if(afu_csr_axi_lite_if),
        .rst_n(rst_n),
        .push(tx_b_valid),
        .push_data(tx_b),
        .pop(b_pop),
        .not_empty(b_not_empty),
        .head(b_head),
        .overflow(tx_overflow[1])
    );

    tlp_ab_arbiter arb_i
    (
        .afu_csr_axi_lite_if(afu_csr_axi_lite_if),
        .rst_n(rst_n),
        .a_ready(a_not_empty),
        .a_head(a_head),
        .b_ready(b_not_empty),
        .b_head(b_head),
        .a_pop(a_pop),
        .b_pop(b_pop),
        .out_valid(tx_arb_valid),
        .out(tx_arb)
    );

    // Final stage feeds the FIM TX stream and the RX B commit path
    tlp_local_commit commit_i
    (
        .afu_csr_axi_lite_if(afu_csr_axi_lite_if),
        .rst_n(rst_n),
        .in_valid(tx_arb_valid),
        .in(tx_arb),
        .tx_valid(fim_tx_valid),
        .tx(fim_tx),
        .commit_valid(commit_valid),
        .commit(commit)
    );

endmodule

//--- verif/tb_pcie_ss_tlp_port.sv
// Testbench for the PCIe TLP port with stimulus, scoreboard queues, assertions and report
`timescale 1ns/1ps
`include "pcie_tlp_settings.svh"

module tb_pcie_ss_tlp_port import pcie_tlp_pkg::*; ();

    localparam int DEPTH        = `PCIE_TLP_QUEUE_DEPTH;
    localparam int RESET_CYCLES = 4;
    localparam int PHASE1_LEN   = 60;
    localparam int PHASE2_LEN   = 60;
    localparam int PHASE3_LEN   = 20;
    // Stimulus length plus room for the pipeline to drain
    localparam int CYCLE_LIMIT  = RESET_CYCLES + PHASE1_LEN + PHASE2_LEN + PHASE3_LEN + 50;

    logic        afu_csr_axi_lite_if;
    logic        rst_n;
    logic        tx_a_valid;
    tlp_hdr_t    tx_a;
    logic        tx_b_valid;
    tlp_hdr_t    tx_b;
    logic        fim_tx_valid;
    tlp_tx_t     fim_tx;
    logic        commit_valid;
    tlp_commit_t commit;
    logic [1:0]  tx_overflow;

    // Scoreboard per port where index 0 is A and index 1 is B
    tlp_hdr_t    sb [2][$];
    // Acceptance cycle of each entry or -1 when the path was not idle
    int          stamp [2][$];
    // One flag per modeled grant that is set when both queues were waiting
    logic        busy_q [$];
    int          cnt [2];
    logic        turn_b;
    logic [1:0]  ovf_exp;
    logic        last_port;
    logic [1:0]  grant;
    logic [1:0]  push_v;
    tlp_hdr_t    push_d [2];
    logic        quiet;
    logic        both;
    tlp_hdr_t    exp_hdr;
    int          exp_stamp;
    logic        out_port;
    logic        sparse_b;
    int          cycle = 0;
    int          errors = 0;
    logic [31:0] rng_state;

    pcie_ss_tlp_port dut_i
    (
        .afu_csr_axi_lite_if(afu_csr_axi_lite_if),
        .rst_n(rst_n),
        .tx_a_valid(tx_a_valid),
        .tx_a(tx_a),
        .tx_b_valid(tx_b_valid),
        .tx_b(tx_b),
        .fim_tx_valid(fim_tx_valid),
        .fim_tx(fim_tx),
        .commit_valid(commit_valid),
        .commit(commit),
        .tx_overflow(tx_overflow)
    );

    always #20 afu_csr_axi_lite_if = ~afu_csr_axi_lite_if;

    always @(posedge afu_csr_axi_lite_if) cycle <= cycle + 1;

    task automatic report_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        errors++;
        $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic tlp_hdr_t random_tlp();
        tlp_hdr_t t;
        t.kind = tlp_kind_e'(next_random() % 3);
        t.tag  = 8'(next_random());
        t.addr = next_random();
        t.data = next_random();
        return t;
    endfunction

    // Strobes are applied 1 ns after the edge and held for one full cycle
    task automatic drive_cycle(input logic a_en, input logic b_en);
        @(posedge afu_csr_axi_lite_if);
        #1;
        tx_a_valid = a_en;
        tx_a       = a_en ? random_tlp() : '0;
        tx_b_valid = b_en;
        tx_b       = b_en ? random_tlp() : '0;
    endtask

    // Every memory write on fim_tx carries its commit in the same cycle
    assert property (@(posedge afu_csr_axi_lite_if) disable iff (!rst_n)
        (fim_tx_valid && fim_tx.hdr.kind == MEM_WR) |-> commit_valid)
        else report_value("commit_valid", 1, $sampled(commit_valid));
    assert property (@(posedge afu_csr_axi_lite_if) disable iff (!rst_n)
        (fim_tx_valid && fim_tx.hdr.kind == MEM_WR) |-> commit.tag == fim_tx.hdr.tag)
        else report_value("commit.tag", $sampled(fim_tx.hdr.tag), $sampled(commit.tag));
    assert property (@(posedge afu_csr_axi_lite_if) disable iff (!rst_n)
        (fim_tx_valid && fim_tx.hdr.kind == MEM_WR) |-> commit.port == fim_tx.port)
        else report_value("commit.port", $sampled(fim_tx.port), $sampled(commit.port));
    assert property (@(posedge afu_csr_axi_lite_if) disable iff (!rst_n)
        commit_valid |-> (fim_tx_valid && fim_tx.hdr.kind == MEM_WR))
        else report_failure("commit_valid was high without a memory write on fim_tx");

    // Reference model of both queues and the round-robin grant and the output checks
    always @(posedge afu_csr_axi_lite_if)
    begin
        if (!rst_n)
        begin
            cnt[0]    = 0;
            cnt[1]    = 0;
            turn_b    = 1'b0;
            ovf_exp   = 2'b00;
            // No grant yet, so the first contended grant must go to A
            last_port = 1'b1;
        end
        else
        begin
            assert (tx_overflow == ovf_exp)
                else report_value("tx_overflow", ovf_exp, tx_overflow);
            if (fim_tx_valid)
            begin
                out_port = fim_tx.port;
                if (sb[out_port].size() == 0)
                begin
                    report_failure($sformatf("fim_tx sent a TLP on port %0d that was never accepted",
                                             out_port));
                end
                else
                begin
                    exp_hdr   = sb[out_port].pop_front();
                    exp_stamp = stamp[out_port].pop_front();
                    assert (fim_tx.hdr == exp_hdr)
                        else report_value("fim_tx.hdr", exp_hdr, fim_tx.hdr);
                    if (exp_stamp >= 0)
                    begin
                        assert (cycle - exp_stamp == 3)
                            else report_value("fim_tx latency", 3, cycle - exp_stamp);
                    end
                end
                if (busy_q.size() != 0 && busy_q.pop_front())
                begin
                    assert (out_port != last_port)
                        else report_value("fim_tx.port", !last_port, out_port);
                end
                last_port = out_port;
            end
            // Grant decision uses the occupancy seen before this edge
            quiet    = (cnt[0] == 0) && (cnt[1] == 0);
            both     = (cnt[0] != 0) && (cnt[1] != 0);
            grant[0] = (cnt[0] != 0) && ((cnt[1] == 0) || !turn_b);
            grant[1] = (cnt[1] != 0) && ((cnt[0] == 0) || turn_b);
            if (grant != 2'b00)
            begin
                busy_q.push_back(both);
                turn_b = grant[0];
            end
            cnt[0]    = cnt[0] - grant[0];
            cnt[1]    = cnt[1] - grant[1];
            push_v    = {tx_b_valid, tx_a_valid};
            push_d[0] = tx_a;
            push_d[1] = tx_b;
            // The pop above has already freed a slot when a push meets a full queue
            for (int p = 0; p < 2; p++)
            begin
                if (push_v[p] && cnt[p] < DEPTH)
                begin
                    cnt[p]++;
                    sb[p].push_back(push_d[p]);
                    stamp[p].push_back((quiet && !push_v[1 - p]) ? cycle : -1);
                end
                else if (push_v[p])
                begin
                    ovf_exp[p] = 1'b1;
                end
            end
        end
    end

    always @(posedge afu_csr_axi_lite_if)
    begin
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles with %0d TLPs from A and %0d from B still pending",
                     cycle, sb[0].size(), sb[1].size());
            $display("Checks finished with %0d errors", errors);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        rng_state           = 32'd59;
        afu_csr_axi_lite_if = 1'b0;
        rst_n               = 1'b0;
        tx_a_valid          = 1'b0;
        tx_a                = '0;
        tx_b_valid          = 1'b0;
        tx_b                = '0;
        repeat (RESET_CYCLES) @(posedge afu_csr_axi_lite_if);
        #1;
        rst_n = 1'b1;
        // Sparse single-port TLPs go into an idle port so each one is alone in flight
        for (int i = 0; i < PHASE1_LEN / 5; i++)
        begin
            sparse_b = next_random() % 2;
            drive_cycle(!sparse_b, sparse_b);
            repeat (4) drive_cycle(1'b0, 1'b0);
        end
        // Both ports strobe at most every other cycle and often together
        for (int i = 0; i < PHASE2_LEN / 2; i++)
        begin
            drive_cycle(next_random() % 4 != 0, next_random() % 4 != 0);
            drive_cycle(1'b0, 1'b0);
        end
        // B bursts every cycle while A takes every other grant, so B fills up
        for (int i = 0; i < PHASE3_LEN; i++)
        begin
            drive_cycle(i % 2 == 0, 1'b1);
        end
        while (sb[0].size() != 0 || sb[1].size() != 0)
        begin
            drive_cycle(1'b0, 1'b0);
        end
        repeat (3) drive_cycle(1'b0, 1'b0);
        if (!ovf_exp[1])
        begin
            report_failure("the port B burst never overfilled its queue");
        end
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/pcie_tlp_pkg.sv
verilog/tlp_port_queue.sv
verilog/tlp_ab_arbiter.sv
verilog/tlp_local_commit.sv
verilog/pcie_ss_tlp_port.sv
verif/tb_pcie_ss_tlp_port.sv
